//--- src/intra_pred_pkg.sv
//========================================
// Shared widths, limits, enums and structs
// for the streaming intra predictor. Each
// design file refers to them by scoped name.
//========================================

package intra_pred_pkg;

    //========================================
    // Widths and limits
    //========================================

    // 10-bit samples
    localparam int PIXEL_W = 10;

    // Largest block edge in pixels
    localparam int MAX_BLOCK = 16;

    // Row or column index, 0..15
    localparam int POS_W = 4;

    // Block size code, legal values 2, 3 and 4
    localparam int SIZE_LOG2_W = 3;

    // 32 samples of 1023 plus rounding still fit
    localparam int DC_SUM_W = 15;

    //========================================
    // Types
    //========================================

    typedef logic [PIXEL_W-1:0] pixel_t;

    // Prediction modes kept from the AV2 set
    typedef enum logic [1:0] {
        MODE_DC    = 2'd0,
        MODE_V     = 2'd1,
        MODE_H     = 2'd2,
        MODE_PAETH = 2'd3
    } pred_mode_t;

    // Control FSM states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_ACCUM   = 2'd1,
        ST_PREDICT = 2'd2,
        ST_DONE    = 2'd3
    } ctrl_state_t;

    // Block configuration, captured at start
    typedef struct packed {
        pred_mode_t             mode;
        logic [SIZE_LOG2_W-1:0] size_log2;
    } pred_cfg_t;

    // Raster position with its end flags
    typedef struct packed {
        logic [POS_W-1:0] row;
        logic [POS_W-1:0] col;
        logic             row_last;
        logic             block_last;
    } scan_pos_t;

endpackage

//--- src/intra_pred_ctrl.sv
//========================================
// Control FSM of the intra predictor.
// Captures the block configuration at start
// and sequences DC accumulation, the pixel
// stream and the done pulse.
//========================================

`timescale 1ns/1ps

module intra_pred_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      ready,
    input  intra_pred_pkg::pred_cfg_t cfg_in,
    input  intra_pred_pkg::scan_pos_t pos,
    output intra_pred_pkg::pred_cfg_t cfg,
    output logic                      scan_clear,
    output logic                      scan_advance,
    output logic                      acc_clear,
    output logic                      acc_enable,
    output logic                      pixel_valid,
    output logic                      done,
    output logic                      busy
);

    intra_pred_pkg::ctrl_state_t state;
    intra_pred_pkg::ctrl_state_t state_next;
    logic                        start_accept;

    // start has no effect once a block is in flight
    assign start_accept = start && (state == intra_pred_pkg::ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= intra_pred_pkg::ST_IDLE;
            cfg   <= '0;
        end else begin
            state <= state_next;
            if (start_accept) begin
                cfg <= cfg_in;
            end
        end
    end

    always_comb begin
        state_next   = state;
        scan_clear   = 1'b0;
        scan_advance = 1'b0;
        acc_clear    = 1'b0;
        acc_enable   = 1'b0;
        case (state)
            intra_pred_pkg::ST_IDLE: begin
                if (start_accept) begin
                    scan_clear = 1'b1;
                    acc_clear  = 1'b1;
                    // Only DC needs the reference sum first
                    if (cfg_in.mode == intra_pred_pkg::MODE_DC) begin
                        state_next = intra_pred_pkg::ST_ACCUM;
                    end else begin
                        state_next = intra_pred_pkg::ST_PREDICT;
                    end
                end
            end
            intra_pred_pkg::ST_ACCUM: begin
                // One top and one left reference per cycle, indexed by col
                acc_enable = 1'b1;
                if (pos.row_last) begin
                    scan_clear = 1'b1;
                    state_next = intra_pred_pkg::ST_PREDICT;
                end else begin
                    scan_advance = 1'b1;
                end
            end
            intra_pred_pkg::ST_PREDICT: begin
                if (ready) begin
                    scan_advance = 1'b1;
                    if (pos.block_last) begin
                        state_next = intra_pred_pkg::ST_DONE;
                    end
                end
            end
            default: begin
                state_next = intra_pred_pkg::ST_IDLE;
            end
        endcase
    end

    assign pixel_valid = (state == intra_pred_pkg::ST_PREDICT);
    assign done        = (state == intra_pred_pkg::ST_DONE);
    assign busy        = (state != intra_pred_pkg::ST_IDLE);

endmodule

//--- src/block_scan_counter.sv
//========================================
// Raster row and column counter for one
// square block. The edge length follows the
// captured size code.
//========================================

`timescale 1ns/1ps

module block_scan_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  intra_pred_pkg::pred_cfg_t cfg,
    input  logic                      scan_clear,
    input  logic                      scan_advance,
    output intra_pred_pkg::scan_pos_t pos
);

    logic [intra_pred_pkg::POS_W-1:0] row;
    logic [intra_pred_pkg::POS_W-1:0] col;
    logic [intra_pred_pkg::POS_W-1:0] last_idx;
    logic                             col_at_end;
    logic                             row_at_end;

    // N-1 as a mask of size_log2 low ones
    assign last_idx = ~({intra_pred_pkg::POS_W{1'b1}} << cfg.size_log2);

    assign col_at_end = (col == last_idx);
    assign row_at_end = (row == last_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (scan_clear) begin
            row <= '0;
            col <= '0;
        end else if (scan_advance) begin
            if (col_at_end) begin
                col <= '0;
                // Wrap to the top after the last pixel
                if (row_at_end) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_comb begin
        pos.row        = row;
        pos.col        = col;
        pos.row_last   = col_at_end;
        pos.block_last = col_at_end && row_at_end;
    end

endmodule

//--- src/dc_accumulator.sv
//========================================
// Serial DC sum over the top and left
// references, one pair per enabled cycle,
// and the rounded average of all 2N samples.
//========================================

`timescale 1ns/1ps

module dc_accumulator (
    input  logic                      clk,
    input  logic                      rst_n,
    input  intra_pred_pkg::pred_cfg_t cfg,
    input  logic                      acc_clear,
    input  logic                      acc_enable,
    input  intra_pred_pkg::pixel_t    top_sample,
    input  intra_pred_pkg::pixel_t    left_sample,
    output intra_pred_pkg::pixel_t    dc_value
);

    logic [intra_pred_pkg::DC_SUM_W-1:0]    sum;
    logic [intra_pred_pkg::DC_SUM_W-1:0]    round_bias;
    logic [intra_pred_pkg::DC_SUM_W-1:0]    rounded;
    logic [intra_pred_pkg::DC_SUM_W-1:0]    average;
    logic [intra_pred_pkg::SIZE_LOG2_W:0]   shift_amt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else if (acc_clear) begin
            sum <= '0;
        end else if (acc_enable) begin
            sum <= sum + top_sample + left_sample;
        end
    end

    //========================================
    // Rounded divide by 2N
    //========================================

    // Half of the 2N divisor is N
    assign round_bias = {{(intra_pred_pkg::DC_SUM_W-1){1'b0}}, 1'b1} << cfg.size_log2;
    assign shift_amt  = {1'b0, cfg.size_log2} + 1'b1;
    assign rounded    = sum + round_bias;
    assign average    = rounded >> shift_amt;

    // Average of 10-bit samples stays within 10 bits
    assign dc_value = average[intra_pred_pkg::PIXEL_W-1:0];

endmodule

//--- src/pixel_predictor.sv
//========================================
// Combinational predictor for the pixel at
// the current scan position. Supports DC,
// vertical, horizontal and Paeth modes.
//========================================

`timescale 1ns/1ps

module pixel_predictor (
    input  intra_pred_pkg::pred_cfg_t cfg,
    input  intra_pred_pkg::scan_pos_t pos,
    input  intra_pred_pkg::pixel_t    ref_top  [intra_pred_pkg::MAX_BLOCK],
    input  intra_pred_pkg::pixel_t    ref_left [intra_pred_pkg::MAX_BLOCK],
    input  intra_pred_pkg::pixel_t    ref_top_left,
    input  intra_pred_pkg::pixel_t    dc_value,
    output intra_pred_pkg::pixel_t    pixel
);

    // Magnitude of a signed difference
    function automatic logic [intra_pred_pkg::PIXEL_W:0] abs_dist(
        input logic signed [intra_pred_pkg::PIXEL_W+1:0] value
    );
        logic signed [intra_pred_pkg::PIXEL_W+1:0] mag;
        mag = (value < 0) ? -value : value;
        return mag[intra_pred_pkg::PIXEL_W:0];
    endfunction

    intra_pred_pkg::pixel_t                      top;
    intra_pred_pkg::pixel_t                      left;
    logic signed [intra_pred_pkg::PIXEL_W+1:0]   top_s;
    logic signed [intra_pred_pkg::PIXEL_W+1:0]   left_s;
    logic signed [intra_pred_pkg::PIXEL_W+1:0]   tl_s;
    logic signed [intra_pred_pkg::PIXEL_W+1:0]   diff_left;
    logic signed [intra_pred_pkg::PIXEL_W+1:0]   diff_top;
    logic [intra_pred_pkg::PIXEL_W:0]            p_left;
    logic [intra_pred_pkg::PIXEL_W:0]            p_top;
    logic [intra_pred_pkg::PIXEL_W:0]            p_top_left;
    intra_pred_pkg::pixel_t                      paeth;

    assign top  = ref_top[pos.col];
    assign left = ref_left[pos.row];

    //========================================
    // Paeth
    //========================================

    // Zero-extend before signed math
    assign top_s  = $signed({2'b00, top});
    assign left_s = $signed({2'b00, left});
    assign tl_s   = $signed({2'b00, ref_top_left});

    // base - left = top - tl, base - top = left - tl
    assign diff_left = top_s - tl_s;
    assign diff_top  = left_s - tl_s;

    assign p_left     = abs_dist(diff_left);
    assign p_top      = abs_dist(diff_top);
    assign p_top_left = abs_dist(diff_left + diff_top);

    // Ties go to left, then top
    always_comb begin
        if ((p_left <= p_top) && (p_left <= p_top_left)) begin
            paeth = left;
        end else if (p_top <= p_top_left) begin
            paeth = top;
        end else begin
            paeth = ref_top_left;
        end
    end

    always_comb begin
        case (cfg.mode)
            intra_pred_pkg::MODE_V:     pixel = top;
            intra_pred_pkg::MODE_H:     pixel = left;
            intra_pred_pkg::MODE_PAETH: pixel = paeth;
            default:                    pixel = dc_value;
        endcase
    end

endmodule

//--- src/intra_pred_top.sv
//========================================
// Streaming intra predictor top level.
// Emits one predicted pixel per transfer in
// raster order, held under back-pressure.
//========================================

`timescale 1ns/1ps

module intra_pred_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  intra_pred_pkg::pred_cfg_t cfg_in,
    input  intra_pred_pkg::pixel_t    ref_top  [intra_pred_pkg::MAX_BLOCK],
    input  intra_pred_pkg::pixel_t    ref_left [intra_pred_pkg::MAX_BLOCK],
    input  intra_pred_pkg::pixel_t    ref_top_left,
    input  logic                      ready,
    output intra_pred_pkg::pixel_t    pixel,
    output logic                      pixel_valid,
    output logic                      done,
    output logic                      busy
);

    intra_pred_pkg::pred_cfg_t cfg;
    intra_pred_pkg::scan_pos_t pos;
    intra_pred_pkg::pixel_t    dc_value;
    logic                      scan_clear;
    logic                      scan_advance;
    logic                      acc_clear;
    logic                      acc_enable;

    intra_pred_ctrl intra_pred_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .ready        (ready),
        .cfg_in       (cfg_in),
        .pos          (pos),
        .cfg          (cfg),
        .scan_clear   (scan_clear),
        .scan_advance (scan_advance),
        .acc_clear    (acc_clear),
        .acc_enable   (acc_enable),
        .pixel_valid  (pixel_valid),
        .done         (done),
        .busy         (busy)
    );

    block_scan_counter block_scan_counter_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .scan_clear   (scan_clear),
        .scan_advance (scan_advance),
        .pos          (pos)
    );

    // During accumulation the column walks both reference edges
    dc_accumulator dc_accumulator_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .acc_clear    (acc_clear),
        .acc_enable   (acc_enable),
        .top_sample   (ref_top[pos.col]),
        .left_sample  (ref_left[pos.col]),
        .dc_value     (dc_value)
    );

    pixel_predictor pixel_predictor_i (
        .cfg          (cfg),
        .pos          (pos),
        .ref_top      (ref_top),
        .ref_left     (ref_left),
        .ref_top_left (ref_top_left),
        .dc_value     (dc_value),
        .pixel        (pixel)
    );

endmodule

//--- test/tb_clock_gen.sv
//========================================
// Testbench clock and reset source.
// 100 ns clock, rst_n low for 2 cycles.
//========================================

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Release just after an edge, like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- test/intra_pred_asserts.sv
//========================================
// Protocol assertions for the intra
// predictor, bound to the top level.
// Failures are counted for the testbench.
//========================================

`timescale 1ns/1ps

module intra_pred_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   ready,
    input intra_pred_pkg::pixel_t pixel,
    input logic                   pixel_valid,
    input logic                   done,
    input logic                   busy
);

    int fail_count = 0;

    // Outputs quiet in reset and on the first cycle out of it
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!pixel_valid && !done && !busy))
        else begin fail_count++; $error("outputs active during reset"); end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!pixel_valid && !done && !busy))
        else begin fail_count++; $error("outputs active after reset"); end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin fail_count++; $error("done longer than one cycle"); end

    idle_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !busy)
        else begin fail_count++; $error("busy still high after done"); end

    // Stalled pixel must hold
    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (pixel_valid && !ready) |=> (pixel_valid && $stable(pixel)))
        else begin fail_count++; $error("pixel changed during stall"); end

    valid_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid |-> busy)
        else begin fail_count++; $error("pixel_valid outside busy"); end

endmodule

bind intra_pred_top intra_pred_asserts intra_pred_asserts_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ready       (ready),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .done        (done),
    .busy        (busy)
);

//--- test/intra_pred_tb.sv
//========================================
// Testbench for the streaming intra predictor.
// Runs V, H, DC and Paeth blocks plus mixed
// back-to-back runs against a software model.
//========================================

`timescale 1ns/1ps

module intra_pred_tb;

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    intra_pred_pkg::pred_cfg_t  cfg_in;
    intra_pred_pkg::pixel_t     ref_top  [intra_pred_pkg::MAX_BLOCK];
    intra_pred_pkg::pixel_t     ref_left [intra_pred_pkg::MAX_BLOCK];
    intra_pred_pkg::pixel_t     ref_top_left;
    logic                       ready;
    intra_pred_pkg::pixel_t     pixel;
    logic                       pixel_valid;
    logic                       done;
    logic                       busy;

    logic [31:0]                rng_state = 32'hafeb_f2f0;
    string                      cur_test;
    intra_pred_pkg::pred_mode_t cur_mode;
    int                         cur_log2;
    int                         xfer_count;

    // Mixed back-to-back runs
    intra_pred_pkg::pred_mode_t mix_mode [6] = '{
        intra_pred_pkg::MODE_V, intra_pred_pkg::MODE_DC, intra_pred_pkg::MODE_PAETH,
        intra_pred_pkg::MODE_H, intra_pred_pkg::MODE_DC, intra_pred_pkg::MODE_PAETH
    };
    int                         mix_log2 [6] = '{2, 3, 4, 2, 2, 3};

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    intra_pred_top intra_pred_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .cfg_in       (cfg_in),
        .ref_top      (ref_top),
        .ref_left     (ref_left),
        .ref_top_left (ref_top_left),
        .ready        (ready),
        .pixel        (pixel),
        .pixel_valid  (pixel_valid),
        .done         (done),
        .busy         (busy)
    );

    //========================================
    // Helpers and reference model
    //========================================

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic intra_pred_pkg::pixel_t rand_pixel();
        logic [31:0] r;
        r = next_rand();
        return r[31:22];
    endfunction

    function automatic int magnitude(input int value);
        return (value < 0) ? -value : value;
    endfunction

    // Cycle allowance for one block with room for stalls
    function automatic int block_budget(input int log2);
        int n;
        n = 1 << log2;
        return 4 * (n * n + n + 4);
    endfunction

    function automatic int expected_pixel(input int row, input int col);
        int n, i, sum, t, l, tl, base, pl, pt, ptl;
        n = 1 << cur_log2;
        t = ref_top[col];
        l = ref_left[row];
        tl = ref_top_left;
        case (cur_mode)
            intra_pred_pkg::MODE_V: return t;
            intra_pred_pkg::MODE_H: return l;
            intra_pred_pkg::MODE_PAETH: begin
                base = t + l - tl;
                pl = magnitude(base - l);
                pt = magnitude(base - t);
                ptl = magnitude(base - tl);
                if (pl <= pt && pl <= ptl) return l;
                if (pt <= ptl) return t;
                return tl;
            end
            default: begin
                sum = 0;
                for (i = 0; i < n; i++) begin
                    sum = sum + int'(ref_top[i]) + int'(ref_left[i]);
                end
                return (sum + n) >> (cur_log2 + 1);
            end
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s expected %0d actual %0d", what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    // Near top-left values give many equal Paeth distances
    task automatic fill_refs(input bit tie_refs);
        int i;
        logic [31:0] r;
        ref_top_left = tie_refs ? 10'd512 : rand_pixel();
        for (i = 0; i < intra_pred_pkg::MAX_BLOCK; i++) begin
            ref_top[i] = rand_pixel();
            ref_left[i] = rand_pixel();
            if (tie_refs && (i % 2 == 0)) begin
                r = next_rand();
                ref_top[i] = intra_pred_pkg::pixel_t'(509 + r[31:29] % 7);
                ref_left[i] = intra_pred_pkg::pixel_t'(509 + r[28:26] % 7);
            end
        end
        if (tie_refs) begin
            ref_top[7] = 10'd1023;
            ref_left[7] = 10'd0;
        end
    endtask

    // One block from start to the idle cycle after done
    task automatic run_block(input string name, input intra_pred_pkg::pred_mode_t mode,
                             input int log2, input bit random_ready,
                             input bit tie_refs, input bit restart);
        int n, cycles;
        bit seen_valid, finished;
        logic [31:0] r;
        n = 1 << log2;
        cycles = 0;
        seen_valid = 1'b0;
        finished = 1'b0;
        @(posedge clk);
        #1;
        cur_test = name;
        cur_mode = mode;
        cur_log2 = log2;
        xfer_count = 0;
        fill_refs(tie_refs);
        cfg_in.mode = mode;
        cfg_in.size_log2 = 3'(log2);
        start = 1'b1;
        ready = 1'b1;
        while (!finished) begin
            @(posedge clk);
            cycles++;
            #1;
            // A second start with another mode while busy must be ignored
            start = restart && (cycles == 2);
            cfg_in.mode = start ? intra_pred_pkg::pred_mode_t'(mode ^ 2'b01) : mode;
            r = next_rand();
            ready = random_ready ? (r[31:30] != 2'b00) : 1'b1;
            @(negedge clk);
            if (!seen_valid && pixel_valid) begin
                seen_valid = 1'b1;
                check_value({name, " first pixel latency"},
                            (mode == intra_pred_pkg::MODE_DC) ? n + 1 : 1, cycles);
            end
            finished = done;
        end
        check_value({name, " transfers before done"}, n * n, xfer_count);
        @(posedge clk);
        #1;
        ready = 1'b1;
        @(negedge clk);
        check_value({name, " busy after done"}, 0, busy);
    endtask

    //========================================
    // Transfer monitor
    //========================================

    always @(negedge clk) begin : transfer_monitor
        int row;
        int col;
        if (rst_n && pixel_valid && ready) begin
            row = xfer_count >> cur_log2;
            col = xfer_count & ((1 << cur_log2) - 1);
            check_value($sformatf("%s pixel r%0d c%0d", cur_test, row, col),
                        expected_pixel(row, col), pixel);
            xfer_count++;
        end
    end

    // Stop at the first bound protocol assertion failure
    initial begin : protocol_watch
        wait (intra_pred_top_i.intra_pred_asserts_i.fail_count != 0);
        $display("A protocol assertion failed at time %0t", $time);
        $display("TEST FAILED");
        $fatal(1, "protocol assertion failure");
    end

    initial begin : watchdog
        int budget;
        budget = block_budget(2) + block_budget(3) + block_budget(4) + block_budget(3) + 20;
        foreach (mix_log2[k]) begin
            budget += block_budget(mix_log2[k]);
        end
        repeat (budget) @(posedge clk);
        $display("Run timed out after %0d cycles", budget);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    //========================================
    // Stimulus
    //========================================

    initial begin
        start = 1'b0;
        cfg_in = '0;
        ref_top_left = '0;
        ready = 1'b1;
        foreach (ref_top[i]) begin
            ref_top[i] = '0;
            ref_left[i] = '0;
        end
        @(posedge rst_n);
        run_block("vert_4x4", intra_pred_pkg::MODE_V, 2, 1'b0, 1'b0, 1'b0);
        run_block("horz_8x8_stall", intra_pred_pkg::MODE_H, 3, 1'b1, 1'b0, 1'b0);
        run_block("dc_16x16", intra_pred_pkg::MODE_DC, 4, 1'b0, 1'b0, 1'b0);
        run_block("paeth_8x8_ties", intra_pred_pkg::MODE_PAETH, 3, 1'b1, 1'b1, 1'b0);
        foreach (mix_mode[k]) begin
            run_block($sformatf("mixed_%0d", k), mix_mode[k], mix_log2[k], 1'b1, 1'b0, 1'b1);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

//--- project.f
src/intra_pred_pkg.sv
src/intra_pred_ctrl.sv
src/block_scan_counter.sv
src/dc_accumulator.sv
src/pixel_predictor.sv
src/intra_pred_top.sv
test/tb_clock_gen.sv
test/intra_pred_asserts.sv
test/intra_pred_tb.sv

//--- Bender.yml
package:
  name: intra_pred

sources:
  - files:
      - src/intra_pred_pkg.sv
      - src/intra_pred_ctrl.sv
      - src/block_scan_counter.sv
      - src/dc_accumulator.sv
      - src/pixel_predictor.sv
      - src/intra_pred_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/intra_pred_asserts.sv
      - test/intra_pred_tb.sv
